//--- build.f
soc_pkg.sv
bus_arbiter.sv
bus_decoder.sv
ram_block.sv
led_register.sv
interval_timer.sv
soc_bus_top.sv
tb_soc_bus.sv

//--- bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter(
	input logic clock,
	input logic i_reset,

	input logic i_inst_request,
	input soc_pkg::addr_t i_inst_address,
	output logic o_inst_ready,
	output soc_pkg::data_t o_inst_rdata,

	input logic i_data_request,
	input logic i_data_rw,
	input soc_pkg::addr_t i_data_address,
	input soc_pkg::data_t i_data_wdata,
	output logic o_data_ready,
	output soc_pkg::data_t o_data_rdata,

	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_pkg::addr_t i_dma_address,
	input soc_pkg::data_t i_dma_wdata,
	output logic o_dma_ready,
	output soc_pkg::data_t o_dma_rdata,

	output logic o_bus_request,
	output logic o_bus_rw,
	output soc_pkg::addr_t o_bus_address,
	output soc_pkg::data_t o_bus_wdata,
	input logic i_bus_ready,
	input soc_pkg::data_t i_bus_rdata
);

	soc_pkg::arb_state_t state;
	soc_pkg::port_t grant;
	logic any_request;

	assign any_request = i_data_request || i_dma_request || i_inst_request;

	// Held for the whole transfer, dropped after the ready cycle
	always_ff @(posedge clock)
	begin
		if (i_reset)
			state <= soc_pkg::IDLE;
		else if (state == soc_pkg::IDLE)
		begin
			if (any_request)
				state <= soc_pkg::BUSY;
		end
		else if (i_bus_ready)
			state <= soc_pkg::IDLE;
	end

	// Fixed priority: data, dma, then inst
	always_ff @(posedge clock)
	begin
		if (state == soc_pkg::IDLE)
		begin
			if (i_data_request)
			begin
				grant <= soc_pkg::PORT_DATA;
				o_bus_rw <= i_data_rw;
				o_bus_address <= i_data_address;
				o_bus_wdata <= i_data_wdata;
			end
			else if (i_dma_request)
			begin
				grant <= soc_pkg::PORT_DMA;
				o_bus_rw <= i_dma_rw;
				o_bus_address <= i_dma_address;
				o_bus_wdata <= i_dma_wdata;
			end
			else
			begin
				// Instruction fetch only reads
				grant <= soc_pkg::PORT_INST;
				o_bus_rw <= 1'b0;
				o_bus_address <= i_inst_address;
				o_bus_wdata <= '0;
			end
		end
	end

	assign o_bus_request = (state == soc_pkg::BUSY);

	// Response goes back to the granted port only
	assign o_inst_ready = o_bus_request && (grant == soc_pkg::PORT_INST) && i_bus_ready;
	assign o_data_ready = o_bus_request && (grant == soc_pkg::PORT_DATA) && i_bus_ready;
	assign o_dma_ready = o_bus_request && (grant == soc_pkg::PORT_DMA) && i_bus_ready;

	assign o_inst_rdata = (grant == soc_pkg::PORT_INST) ? i_bus_rdata : '0;
	assign o_data_rdata = (grant == soc_pkg::PORT_DATA) ? i_bus_rdata : '0;
	assign o_dma_rdata = (grant == soc_pkg::PORT_DMA) ? i_bus_rdata : '0;

	// A port only sees ready while it still holds its request
	assert property (@(posedge clock) disable iff (i_reset)
		(!o_inst_ready || i_inst_request) && (!o_data_ready || i_data_request)
			&& (!o_dma_ready || i_dma_request))
		else $error("bus_arbiter: ready to a port without a request");

endmodule

//--- bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder(
	input logic clock,
	input logic i_reset,
	input logic i_bus_request,
	input soc_pkg::addr_t i_bus_address,

	output logic o_ram_request,
	output logic o_led_request,
	output logic o_timer_request,

	input logic i_ram_ready,
	input logic i_led_ready,
	input logic i_timer_ready,
	input soc_pkg::data_t i_ram_rdata,
	input soc_pkg::data_t i_led_rdata,
	input soc_pkg::data_t i_timer_rdata,

	output logic o_bus_ready,
	output soc_pkg::data_t o_bus_rdata
);

	soc_pkg::region_t region;
	logic ram_select;
	logic led_select;
	logic timer_select;
	logic unmapped_ready;

	assign region = i_bus_address[31:28];

	assign ram_select = (region == soc_pkg::REGION_RAM);
	assign led_select = (region == soc_pkg::REGION_LED);
	assign timer_select = (region == soc_pkg::REGION_TIMER);

	assign o_ram_request = i_bus_request && ram_select;
	assign o_led_request = i_bus_request && led_select;
	assign o_timer_request = i_bus_request && timer_select;

	// Unmapped responder, answers like a target so the bus never hangs
	always_ff @(posedge clock)
	begin
		if (i_reset)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= i_bus_request && !ram_select && !led_select
				&& !timer_select && !unmapped_ready;
	end

	always_comb
	begin
		if (ram_select)
		begin
			o_bus_ready = i_ram_ready;
			o_bus_rdata = i_ram_rdata;
		end
		else if (led_select)
		begin
			o_bus_ready = i_led_ready;
			o_bus_rdata = i_led_rdata;
		end
		else if (timer_select)
		begin
			o_bus_ready = i_timer_ready;
			o_bus_rdata = i_timer_rdata;
		end
		else
		begin
			o_bus_ready = unmapped_ready;
			o_bus_rdata = '0;
		end
	end

	// At most one responder answers in a cycle
	assert property (@(posedge clock) disable iff (i_reset)
		$onehot0({i_ram_ready, i_led_ready, i_timer_ready, unmapped_ready}))
		else $error("bus_decoder: two targets answered");

	// Every target answers one cycle after the request rises
	assert property (@(posedge clock) disable iff (i_reset)
		$rose(i_bus_request) |=> o_bus_ready)
		else $error("bus_decoder: late response on the bus");

endmodule

//--- interval_timer.sv
`timescale 1ns/100ps

module interval_timer(
	input logic clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input soc_pkg::addr_t i_address,
	input soc_pkg::data_t i_wdata,
	output logic o_ready,
	output soc_pkg::data_t o_rdata,
	output logic o_irq
);

	soc_pkg::timer_reg_t reg_select;
	logic access;
	logic write;
	logic enable;
	logic irq_enable;
	logic pending;
	logic wrap;
	logic clear;
	soc_pkg::data_t period;
	soc_pkg::data_t count;
	soc_pkg::data_t ctrl_value;

	assign reg_select = i_address[3:2];
	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	assign wrap = enable && (count == period);
	assign clear = write && (reg_select == soc_pkg::TIMER_STATUS) && i_wdata[0];

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			enable <= 1'b0;
			irq_enable <= 1'b0;
			period <= '0;
		end
		else if (write && reg_select == soc_pkg::TIMER_CTRL)
		begin
			enable <= i_wdata[soc_pkg::TIMER_EN_BIT];
			irq_enable <= i_wdata[soc_pkg::TIMER_IRQ_EN_BIT];
		end
		else if (write && reg_select == soc_pkg::TIMER_PERIOD)
			period <= i_wdata;
	end

	// Counts clock cycles, wraps at the period
	always_ff @(posedge clock)
	begin
		if (i_reset || wrap)
			count <= '0;
		else if (enable)
			count <= count + 1'b1;
	end

	// Clear beats a set in the same cycle
	always_ff @(posedge clock)
	begin
		if (i_reset || clear)
			pending <= 1'b0;
		else if (wrap)
			pending <= 1'b1;
	end

	assign o_irq = pending && irq_enable;

	// ========================================
	// Bus response
	// ========================================

	always_comb
	begin
		ctrl_value = '0;
		ctrl_value[soc_pkg::TIMER_EN_BIT] = enable;
		ctrl_value[soc_pkg::TIMER_IRQ_EN_BIT] = irq_enable;
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= access;
	end

	always_ff @(posedge clock)
	begin
		if (access)
		begin
			case (reg_select)
				soc_pkg::TIMER_CTRL: o_rdata <= ctrl_value;
				soc_pkg::TIMER_PERIOD: o_rdata <= period;
				soc_pkg::TIMER_COUNT: o_rdata <= count;
				default: o_rdata <= soc_pkg::data_t'(pending);
			endcase
		end
	end

endmodule

//--- led_register.sv
`timescale 1ns/100ps

module led_register(
	input logic clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input soc_pkg::data_t i_wdata,
	output logic o_ready,
	output soc_pkg::data_t o_rdata,
	output soc_pkg::led_t o_leds
);

	logic write;

	assign write = i_request && !o_ready && i_rw;

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			o_ready <= 1'b0;
			o_leds <= '0;
		end
		else
		begin
			o_ready <= i_request && !o_ready;
			// Low bits drive the LED bank
			if (write)
				o_leds <= i_wdata[9:0];
		end
	end

	assign o_rdata = soc_pkg::data_t'(o_leds);

endmodule

//--- ram_block.sv
`timescale 1ns/100ps

module ram_block(
	input logic clock,
	input logic i_request,
	input logic i_rw,
	input soc_pkg::addr_t i_address,
	input soc_pkg::data_t i_wdata,
	output logic o_ready,
	output soc_pkg::data_t o_rdata
);

	soc_pkg::data_t mem [soc_pkg::RAM_WORDS];
	soc_pkg::ram_index_t index;
	logic first;

	// Word index, upper address bits alias
	assign index = i_address[11:2];

	// Request is still high in the ready cycle
	assign first = i_request && !o_ready;

	always_ff @(posedge clock)
	begin
		o_ready <= first;
	end

	always_ff @(posedge clock)
	begin
		if (first)
		begin
			if (i_rw)
				mem[index] <= i_wdata;
			o_rdata <= mem[index];
		end
	end

	assert property (@(posedge clock)
		o_ready |-> i_request)
		else $error("ram_block: ready without a request");

endmodule

//--- run.sh
#!/bin/bash
# Build and run the bus fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_soc_bus -o Vtb_soc_bus

output="$(./obj_dir/Vtb_soc_bus || true)"
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
	exit 0
fi
exit 1

//--- soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top(
	input logic clock,
	input logic i_reset,

	input logic i_inst_request,
	input soc_pkg::addr_t i_inst_address,
	output logic o_inst_ready,
	output soc_pkg::data_t o_inst_rdata,

	input logic i_data_request,
	input logic i_data_rw,
	input soc_pkg::addr_t i_data_address,
	input soc_pkg::data_t i_data_wdata,
	output logic o_data_ready,
	output soc_pkg::data_t o_data_rdata,

	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_pkg::addr_t i_dma_address,
	input soc_pkg::data_t i_dma_wdata,
	output logic o_dma_ready,
	output soc_pkg::data_t o_dma_rdata,

	output soc_pkg::led_t o_leds,
	output logic o_timer_irq
);

	// ========================================
	// Shared bus
	// ========================================

	logic bus_request;
	logic bus_rw;
	logic bus_ready;
	soc_pkg::addr_t bus_address;
	soc_pkg::data_t bus_wdata;
	soc_pkg::data_t bus_rdata;

	logic ram_request;
	logic ram_ready;
	soc_pkg::data_t ram_rdata;
	logic led_request;
	logic led_ready;
	soc_pkg::data_t led_rdata;
	logic timer_request;
	logic timer_ready;
	soc_pkg::data_t timer_rdata;

	bus_arbiter arbiter(
		.clock(clock),
		.i_reset(i_reset),
		.i_inst_request(i_inst_request),
		.i_inst_address(i_inst_address),
		.o_inst_ready(o_inst_ready),
		.o_inst_rdata(o_inst_rdata),
		.i_data_request(i_data_request),
		.i_data_rw(i_data_rw),
		.i_data_address(i_data_address),
		.i_data_wdata(i_data_wdata),
		.o_data_ready(o_data_ready),
		.o_data_rdata(o_data_rdata),
		.i_dma_request(i_dma_request),
		.i_dma_rw(i_dma_rw),
		.i_dma_address(i_dma_address),
		.i_dma_wdata(i_dma_wdata),
		.o_dma_ready(o_dma_ready),
		.o_dma_rdata(o_dma_rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_decoder decoder(
		.clock(clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_ram_request(ram_request),
		.o_led_request(led_request),
		.o_timer_request(timer_request),
		.i_ram_ready(ram_ready),
		.i_led_ready(led_ready),
		.i_timer_ready(timer_ready),
		.i_ram_rdata(ram_rdata),
		.i_led_rdata(led_rdata),
		.i_timer_rdata(timer_rdata),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

	// ========================================
	// Targets
	// ========================================

	ram_block ram(
		.clock(clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_ready(ram_ready),
		.o_rdata(ram_rdata)
	);

	led_register led(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(led_request),
		.i_rw(bus_rw),
		.i_wdata(bus_wdata),
		.o_ready(led_ready),
		.o_rdata(led_rdata),
		.o_leds(o_leds)
	);

	interval_timer timer(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(timer_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_ready(timer_ready),
		.o_rdata(timer_rdata),
		.o_irq(o_timer_irq)
	);

endmodule

//--- soc_pkg.sv
package soc_pkg;

	// ========================================
	// Bus types
	// ========================================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Top address nibble picks the target
	typedef logic [3:0] region_t;

	typedef logic [9:0] led_t;
	typedef logic [9:0] ram_index_t;

	// Timer register select from address bits 3..2
	typedef logic [1:0] timer_reg_t;

	typedef enum logic { IDLE, BUSY } arb_state_t;

	typedef enum logic [1:0] { PORT_INST, PORT_DATA, PORT_DMA } port_t;

	// ========================================
	// Region map
	// ========================================

	localparam region_t REGION_RAM = 4'h1;
	localparam region_t REGION_LED = 4'h4;
	localparam region_t REGION_TIMER = 4'hA;

	localparam int RAM_WORDS = 1024;

	// Timer register offsets, in words
	localparam timer_reg_t TIMER_CTRL = 2'd0;
	localparam timer_reg_t TIMER_PERIOD = 2'd1;
	localparam timer_reg_t TIMER_COUNT = 2'd2;
	localparam timer_reg_t TIMER_STATUS = 2'd3;

	// Control register bits
	localparam int TIMER_EN_BIT = 0;
	localparam int TIMER_IRQ_EN_BIT = 1;

endpackage

//--- tb_soc_bus.sv
`timescale 1ns/100ps

module tb_soc_bus;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] LCG_SEED = 32'd15;

	logic clock;
	logic i_reset;

	logic inst_request;
	soc_pkg::addr_t inst_address;
	logic data_request;
	logic data_rw;
	soc_pkg::addr_t data_address;
	soc_pkg::data_t data_wdata;
	logic dma_request;
	logic dma_rw;
	soc_pkg::addr_t dma_address;
	soc_pkg::data_t dma_wdata;

	logic inst_ready;
	soc_pkg::data_t inst_rdata;
	logic data_ready;
	soc_pkg::data_t data_rdata;
	logic dma_ready;
	soc_pkg::data_t dma_rdata;
	soc_pkg::led_t leds;
	logic timer_irq;

	int errors;
	int cycle_count;
	logic [31:0] lcg_state;

	// Per-port latency and completion cycle of the last transaction
	int inst_latency;
	int data_latency;
	int dma_latency;
	int inst_done;
	int data_done;
	int dma_done;

	// Reference copy of the RAM contents
	soc_pkg::data_t model_mem [soc_pkg::RAM_WORDS];
	soc_pkg::ram_index_t written [$];

	soc_bus_top dut(
		.clock(clock),
		.i_reset(i_reset),
		.i_inst_request(inst_request),
		.i_inst_address(inst_address),
		.o_inst_ready(inst_ready),
		.o_inst_rdata(inst_rdata),
		.i_data_request(data_request),
		.i_data_rw(data_rw),
		.i_data_address(data_address),
		.i_data_wdata(data_wdata),
		.o_data_ready(data_ready),
		.o_data_rdata(data_rdata),
		.i_dma_request(dma_request),
		.i_dma_rw(dma_rw),
		.i_dma_address(dma_address),
		.i_dma_wdata(dma_wdata),
		.o_dma_ready(dma_ready),
		.o_dma_rdata(dma_rdata),
		.o_leds(leds),
		.o_timer_irq(timer_irq)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("ERROR: timeout after %0d cycles, %0d errors so far", cycle_count, errors);
			$display("Test failed");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic soc_pkg::addr_t ram_address(input soc_pkg::ram_index_t index,
			input logic [15:0] alias_bits);
		return {soc_pkg::REGION_RAM, alias_bits, index, 2'b00};
	endfunction

	function automatic soc_pkg::addr_t timer_address(input soc_pkg::timer_reg_t select);
		return {soc_pkg::REGION_TIMER, 24'h0, select, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// Ready and read data are sampled on the falling edge
	task automatic inst_read(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata);
		inst_latency = 0;
		@(posedge clock);
		inst_request <= 1'b1;
		inst_address <= addr;
		do
		begin
			@(negedge clock);
			inst_latency++;
		end while (!inst_ready);
		rdata = inst_rdata;
		inst_done = cycle_count;
		@(posedge clock);
		inst_request <= 1'b0;
	endtask

	task automatic data_access(input logic rw, input soc_pkg::addr_t addr,
			input soc_pkg::data_t wdata, output soc_pkg::data_t rdata);
		data_latency = 0;
		@(posedge clock);
		data_request <= 1'b1;
		data_rw <= rw;
		data_address <= addr;
		data_wdata <= wdata;
		do
		begin
			@(negedge clock);
			data_latency++;
		end while (!data_ready);
		rdata = data_rdata;
		data_done = cycle_count;
		@(posedge clock);
		data_request <= 1'b0;
	endtask

	task automatic dma_access(input logic rw, input soc_pkg::addr_t addr,
			input soc_pkg::data_t wdata, output soc_pkg::data_t rdata);
		dma_latency = 0;
		@(posedge clock);
		dma_request <= 1'b1;
		dma_rw <= rw;
		dma_address <= addr;
		dma_wdata <= wdata;
		do
		begin
			@(negedge clock);
			dma_latency++;
		end while (!dma_ready);
		rdata = dma_rdata;
		dma_done = cycle_count;
		@(posedge clock);
		dma_request <= 1'b0;
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic test_reset_state();
		@(negedge clock);
		check_value("o_leds", 32'(leds), 32'h0);
		check_value("o_timer_irq", 32'(timer_irq), 32'h0);
		check_value("o_inst_ready", 32'(inst_ready), 32'h0);
		check_value("o_data_ready", 32'(data_ready), 32'h0);
		check_value("o_dma_ready", 32'(dma_ready), 32'h0);
	endtask

	task automatic test_ram_round_trip();
		logic [31:0] rnd;
		soc_pkg::data_t wdata;
		soc_pkg::data_t rdata;
		soc_pkg::ram_index_t index;
		soc_pkg::addr_t addr;
		string name;
		for (int i = 0; i < 20; i++)
		begin
			rnd = lcg_next();
			index = rnd[11:2];
			wdata = lcg_next();
			// Random upper bits exercise the address aliasing
			if (i % 2 == 0)
				data_access(1'b1, ram_address(index, rnd[27:12]), wdata, rdata);
			else
				dma_access(1'b1, ram_address(index, rnd[27:12]), wdata, rdata);
			model_mem[index] = wdata;
			written.push_back(index);
		end
		foreach (written[i])
		begin
			for (int port = 0; port < 3; port++)
			begin
				rnd = lcg_next();
				addr = ram_address(written[i], rnd[27:12]);
				case (port)
					0:
					begin
						name = "o_inst_rdata";
						inst_read(addr, rdata);
					end
					1:
					begin
						name = "o_data_rdata";
						data_access(1'b0, addr, '0, rdata);
					end
					default:
					begin
						name = "o_dma_rdata";
						dma_access(1'b0, addr, '0, rdata);
					end
				endcase
				check_value(name, rdata, model_mem[written[i]]);
			end
		end
	endtask

	task automatic test_led_register();
		soc_pkg::data_t wdata;
		soc_pkg::data_t rdata;
		wdata = lcg_next();
		data_access(1'b1, 32'h4000_0000, wdata, rdata);
		@(negedge clock);
		check_value("o_leds", 32'(leds), wdata & 32'h3FF);
		inst_read(32'h4000_0010, rdata);
		check_value("o_inst_rdata", rdata, wdata & 32'h3FF);
	endtask

	task automatic test_unmapped();
		soc_pkg::data_t rdata;
		soc_pkg::led_t leds_before;
		soc_pkg::ram_index_t index;
		index = written[0];
		leds_before = leds;
		inst_read(32'h0000_0040, rdata);
		check_value("o_inst_rdata", rdata, 32'h0);
		dma_access(1'b0, 32'h7000_1000, '0, rdata);
		check_value("o_dma_rdata", rdata, 32'h0);
		// Same word index as a RAM location, but outside the RAM region
		data_access(1'b1, {4'h0, 16'h0, index, 2'b00}, 32'hDEAD_BEEF, rdata);
		dma_access(1'b1, {4'h7, 16'h0, index, 2'b00}, 32'hCAFE_F00D, rdata);
		@(negedge clock);
		check_value("o_leds", 32'(leds), 32'(leds_before));
		data_access(1'b0, ram_address(index, 16'h0), '0, rdata);
		check_value("o_data_rdata", rdata, model_mem[index]);
	endtask

	task automatic test_priority();
		soc_pkg::data_t inst_value;
		soc_pkg::data_t data_value;
		soc_pkg::data_t dma_value;
		fork
			data_access(1'b0, ram_address(written[1], 16'h0), '0, data_value);
			dma_access(1'b0, ram_address(written[2], 16'h0), '0, dma_value);
			inst_read(ram_address(written[3], 16'h0), inst_value);
		join
		check_value("o_data_rdata", data_value, model_mem[written[1]]);
		check_value("o_dma_rdata", dma_value, model_mem[written[2]]);
		check_value("o_inst_rdata", inst_value, model_mem[written[3]]);
		check_value("data latency", data_latency, 32'd3);
		if (!(data_done < dma_done && dma_done < inst_done))
		begin
			$display("ERROR: ready order was not data, dma, inst (cycles %0d %0d %0d)",
				data_done, dma_done, inst_done);
			errors++;
		end
	endtask

	task automatic test_latency();
		soc_pkg::data_t rdata;
		inst_read(ram_address(written[4], 16'h0), rdata);
		check_value("inst latency", inst_latency, 32'd3);
		check_value("o_inst_rdata", rdata, model_mem[written[4]]);
		dma_access(1'b0, ram_address(written[5], 16'h0), '0, rdata);
		check_value("dma latency", dma_latency, 32'd3);
	endtask

	task automatic test_timer();
		soc_pkg::data_t rdata;
		int wait_cycles;
		data_access(1'b1, timer_address(soc_pkg::TIMER_PERIOD), 32'd9, rdata);
		data_access(1'b1, timer_address(soc_pkg::TIMER_CTRL), 32'h3, rdata);
		wait_cycles = 0;
		do
		begin
			@(negedge clock);
			wait_cycles++;
		end while (!timer_irq && wait_cycles < 12);
		if (!timer_irq)
		begin
			$display("ERROR: timer interrupt did not arrive within 12 cycles");
			errors++;
		end
		data_access(1'b0, timer_address(soc_pkg::TIMER_STATUS), '0, rdata);
		check_value("timer status", rdata, 32'h1);
		// Stop counting so the clear cannot meet a new wrap
		data_access(1'b1, timer_address(soc_pkg::TIMER_CTRL), 32'h2, rdata);
		@(negedge clock);
		check_value("o_timer_irq", 32'(timer_irq), 32'h1);
		data_access(1'b1, timer_address(soc_pkg::TIMER_STATUS), 32'h1, rdata);
		@(negedge clock);
		check_value("o_timer_irq", 32'(timer_irq), 32'h0);
		// Counting with the interrupt masked
		data_access(1'b1, timer_address(soc_pkg::TIMER_CTRL), 32'h1, rdata);
		repeat (15)
		begin
			@(negedge clock);
			check_value("o_timer_irq", 32'(timer_irq), 32'h0);
		end
		data_access(1'b0, timer_address(soc_pkg::TIMER_STATUS), '0, rdata);
		check_value("timer status", rdata, 32'h1);
		data_access(1'b1, timer_address(soc_pkg::TIMER_CTRL), 32'h0, rdata);
	endtask

	// ========================================
	// Sequence
	// ========================================

	initial
	begin
		clock = 1'b0;
		i_reset = 1'b1;
		inst_request = 1'b0;
		inst_address = '0;
		data_request = 1'b0;
		data_rw = 1'b0;
		data_address = '0;
		data_wdata = '0;
		dma_request = 1'b0;
		dma_rw = 1'b0;
		dma_address = '0;
		dma_wdata = '0;
		errors = 0;
		cycle_count = 0;
		lcg_state = LCG_SEED;
		repeat (3) @(posedge clock);
		i_reset <= 1'b0;
		test_reset_state();
		test_ram_round_trip();
		test_led_register();
		test_unmapped();
		test_priority();
		test_latency();
		test_timer();
		repeat (2) @(negedge clock);
		$display("Run finished after %0d cycles with %0d errors", cycle_count, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
